/* design/ctxt_event_latch.sv */
`timescale 1ns/1ns

module ctxt_event_latch
   (input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        clear_i,
    input  logic                        error_i,
    input  ctxt_types_pkg::message_t    message_i,
    input  ctxt_types_pkg::ctxt_state_e state_i,
    input  logic                        wr_ready_i,
    output ctxt_types_pkg::message_t    message_o);

   ctxt_types_pkg::message_t message_q;
   logic                     flowctrl_done;

   // The flow-control word always has wr_valid high, so ready alone means accepted.
   assign flowctrl_done = (state_i == ctxt_types_pkg::FLOWCTRL) && wr_ready_i;

   // ******************************
   // Stored message
   // ******************************

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         message_q <= '0;
      end
      else if (error_i)
      begin
         message_q <= message_i;     // Newest error wins.
      end
      else if (flowctrl_done)
      begin
         message_q <= '0;            // Packet carried it out.
      end
   end

   assign message_o = message_q;

endmodule

/* design/ctxt_fifo.sv */
`timescale 1ns/1ns

module ctxt_fifo
   (input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       clear_i,
    input  ctxt_types_pkg::ctxt_word_t wr_data_i,
    input  logic                       wr_valid_i,
    output logic                       wr_ready_o,
    output ctxt_types_pkg::ctxt_word_t rd_data_o,
    output logic                       rd_valid_o,
    input  logic                       rd_ready_i);

   ctxt_types_pkg::ctxt_word_t          mem_q [ctxt_fmt_pkg::FIFO_DEPTH];
   logic [ctxt_fmt_pkg::FIFO_AW-1:0]    wr_ptr_q, rd_ptr_q;
   logic [ctxt_fmt_pkg::FIFO_AW:0]      count_q;
   ctxt_types_pkg::ctxt_word_t          out_q;
   logic                                out_valid_q;
   logic                                wr_en, out_load, bypass, push, pop;

   // ******************************
   // Handshake decode
   // ******************************

   assign wr_ready_o = (count_q != (ctxt_fmt_pkg::FIFO_AW+1)'(ctxt_fmt_pkg::FIFO_DEPTH));
   assign wr_en      = wr_valid_i && wr_ready_o;
   assign out_load   = !out_valid_q || rd_ready_i;   // Output register free next edge.
   assign pop        = out_load && (count_q != '0);
   assign bypass     = wr_en && out_load && (count_q == '0);
   assign push       = wr_en && !bypass;

   // Storage, no reset. Pointers wrap at the power-of-two depth.
   always_ff @(posedge clk)
   begin
      if (push)
         mem_q[wr_ptr_q] <= wr_data_i;
      if (pop)
         out_q <= mem_q[rd_ptr_q];
      else if (bypass)
         out_q <= wr_data_i;                          // Empty FIFO goes straight out.
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         count_q     <= '0;
         out_valid_q <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q <= count_q + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
         if (out_load)
            out_valid_q <= pop || bypass;
      end
   end

   assign rd_data_o  = out_q;
   assign rd_valid_o = out_valid_q;

endmodule

/* design/ctxt_fmt_pkg.sv */
package ctxt_fmt_pkg;

   // ******************************
   // Header
   // ******************************

   localparam logic [11:0] HDR_PKT_CODE = 12'h50D;    // Context packet type.
   localparam logic [15:0] HDR_PKT_SIZE = 16'd7;      // Packet size field.

   // Header bit set when the packet has no protocol-engine word.
   localparam int HDR_NO_PE_BIT = 28;

   // ******************************
   // Protocol-engine word
   // ******************************

   localparam logic [15:0] PE_WORD_A = 16'd1;         // Upper half.
   localparam logic [15:0] PE_WORD_B = 16'd28;        // Lower half.

   // ******************************
   // Output FIFO
   // ******************************

   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

/* design/ctxt_pkt_gen.sv */
`timescale 1ns/1ns

module ctxt_pkt_gen
  #(parameter bit PROT_ENG_EN = 1'b1)
   (input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       clear_i,
    input  logic                       trigger_i,
    input  logic                       error_i,
    input  ctxt_types_pkg::stream_id_t stream_id_i,
    input  ctxt_types_pkg::vita_time_t vita_time_i,
    input  ctxt_types_pkg::message_t   message_i,
    input  ctxt_types_pkg::seqnum_t    seqnum0_i,
    input  ctxt_types_pkg::seqnum_t    seqnum1_i,
    output logic                       sent_o,
    output ctxt_types_pkg::ctxt_word_t data_o,
    output logic                       src_rdy_o,
    input  logic                       dst_rdy_i);

   ctxt_types_pkg::ctxt_state_e state;
   ctxt_types_pkg::vita_time_t  evt_time;
   ctxt_types_pkg::pkt_seq_t    pkt_seq;
   ctxt_types_pkg::message_t    message;
   ctxt_types_pkg::ctxt_word_t  word;
   logic                        wr_valid, wr_ready;

   ctxt_seq_fsm #(.PROT_ENG_EN(PROT_ENG_EN)) ctxt_seq_fsm_i
     (.clk(clk), .rst_n_i(rst_n_i), .clear_i(clear_i),
      .trigger_i(trigger_i), .vita_time_i(vita_time_i),
      .wr_ready_i(wr_ready), .state_o(state), .wr_valid_o(wr_valid),
      .evt_time_o(evt_time), .pkt_seq_o(pkt_seq), .sent_o(sent_o));

   ctxt_event_latch ctxt_event_latch_i
     (.clk(clk), .rst_n_i(rst_n_i), .clear_i(clear_i),
      .error_i(error_i), .message_i(message_i),
      .state_i(state), .wr_ready_i(wr_ready), .message_o(message));

   ctxt_word_mux #(.PROT_ENG_EN(PROT_ENG_EN)) ctxt_word_mux_i
     (.state_i(state), .stream_id_i(stream_id_i), .evt_time_i(evt_time),
      .message_i(message), .pkt_seq_i(pkt_seq),
      .seqnum0_i(seqnum0_i), .seqnum1_i(seqnum1_i), .word_o(word));

   // Downstream side keeps the ready/ready handshake.
   ctxt_fifo ctxt_fifo_i
     (.clk(clk), .rst_n_i(rst_n_i), .clear_i(clear_i),
      .wr_data_i(word), .wr_valid_i(wr_valid), .wr_ready_o(wr_ready),
      .rd_data_o(data_o), .rd_valid_o(src_rdy_o), .rd_ready_i(dst_rdy_i));

endmodule

/* design/ctxt_seq_fsm.sv */
`timescale 1ns/1ns

module ctxt_seq_fsm
  #(parameter bit PROT_ENG_EN = 1'b1)
   (input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        clear_i,
    input  logic                        trigger_i,
    input  ctxt_types_pkg::vita_time_t  vita_time_i,
    input  logic                        wr_ready_i,
    output ctxt_types_pkg::ctxt_state_e state_o,
    output logic                        wr_valid_o,
    output ctxt_types_pkg::vita_time_t  evt_time_o,
    output ctxt_types_pkg::pkt_seq_t    pkt_seq_o,
    output logic                        sent_o);

   ctxt_types_pkg::ctxt_state_e state_q;
   ctxt_types_pkg::ctxt_state_e next_word;
   ctxt_types_pkg::vita_time_t  evt_time_q;
   ctxt_types_pkg::pkt_seq_t    pkt_seq_q;

   // State that follows each word state.
   always_comb
   begin
      case (state_q)
         ctxt_types_pkg::PROT_ENG : next_word = ctxt_types_pkg::HEADER;
         ctxt_types_pkg::HEADER   : next_word = ctxt_types_pkg::STREAMID;
         ctxt_types_pkg::STREAMID : next_word = ctxt_types_pkg::SECS;
         ctxt_types_pkg::SECS     : next_word = ctxt_types_pkg::TICS_HI;
         ctxt_types_pkg::TICS_HI  : next_word = ctxt_types_pkg::TICS_LO;
         ctxt_types_pkg::TICS_LO  : next_word = ctxt_types_pkg::MESSAGE;
         ctxt_types_pkg::MESSAGE  : next_word = ctxt_types_pkg::FLOWCTRL;
         ctxt_types_pkg::FLOWCTRL : next_word = ctxt_types_pkg::DONE;
         default                  : next_word = ctxt_types_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         state_q   <= ctxt_types_pkg::IDLE;
         pkt_seq_q <= '0;
      end
      else
      begin
         case (state_q)
            ctxt_types_pkg::IDLE :
               if (trigger_i)
                  state_q <= PROT_ENG_EN ? ctxt_types_pkg::PROT_ENG : ctxt_types_pkg::HEADER;
            ctxt_types_pkg::DONE :
            begin
               state_q   <= ctxt_types_pkg::IDLE;
               pkt_seq_q <= pkt_seq_q + 4'd1;    // Wraps after 15.
            end
            default :
               if (wr_ready_i)
                  state_q <= next_word;          // Advance on an accepted write.
         endcase
      end
   end

   // Event time, held for the whole packet.
   always_ff @(posedge clk)
   begin
      if (state_q == ctxt_types_pkg::IDLE && trigger_i)
         evt_time_q <= vita_time_i;
   end

   assign wr_valid_o = (state_q != ctxt_types_pkg::IDLE) && (state_q != ctxt_types_pkg::DONE);
   assign sent_o     = (state_q == ctxt_types_pkg::DONE);
   assign state_o    = state_q;
   assign evt_time_o = evt_time_q;
   assign pkt_seq_o  = pkt_seq_q;

endmodule

/* design/ctxt_types_pkg.sv */
package ctxt_types_pkg;

   // ******************************
   // Width types
   // ******************************

   // Seconds in [63:32], fractional ticks in [31:0].
   typedef logic [63:0] vita_time_t;

   typedef logic [31:0] stream_id_t;
   typedef logic [31:0] message_t;   // Error code carried in the MESSAGE word.
   typedef logic [15:0] seqnum_t;    // Flow-control sequence number.
   typedef logic [3:0]  pkt_seq_t;   // Header packet count, wraps after 15.
   typedef logic [31:0] payload_t;

   // ******************************
   // Packet word
   // ******************************

   typedef struct packed {
      logic     sof;        // First word of the packet.
      logic     eof;        // Last word of the packet.
      payload_t payload;
   } ctxt_word_t;

   // ******************************
   // Packet states
   // ******************************

   typedef enum logic [3:0] {
      IDLE,
      PROT_ENG,
      HEADER,
      STREAMID,
      SECS,
      TICS_HI,
      TICS_LO,
      MESSAGE,
      FLOWCTRL,
      DONE
   } ctxt_state_e;

endpackage

/* design/ctxt_word_mux.sv */
`timescale 1ns/1ns

module ctxt_word_mux
  #(parameter bit PROT_ENG_EN = 1'b1)
   (input  ctxt_types_pkg::ctxt_state_e state_i,
    input  ctxt_types_pkg::stream_id_t  stream_id_i,
    input  ctxt_types_pkg::vita_time_t  evt_time_i,
    input  ctxt_types_pkg::message_t    message_i,
    input  ctxt_types_pkg::pkt_seq_t    pkt_seq_i,
    input  ctxt_types_pkg::seqnum_t     seqnum0_i,
    input  ctxt_types_pkg::seqnum_t     seqnum1_i,
    output ctxt_types_pkg::ctxt_word_t  word_o);

   ctxt_types_pkg::payload_t header;

   always_comb
   begin
      header = {ctxt_fmt_pkg::HDR_PKT_CODE, pkt_seq_i, ctxt_fmt_pkg::HDR_PKT_SIZE};
      if (!PROT_ENG_EN)
         header[ctxt_fmt_pkg::HDR_NO_PE_BIT] = 1'b1;
   end

   // ******************************
   // One word per state
   // ******************************

   always_comb
   begin
      word_o = '0;
      case (state_i)
         ctxt_types_pkg::PROT_ENG :
         begin
            word_o.sof     = 1'b1;
            word_o.payload = {ctxt_fmt_pkg::PE_WORD_A, ctxt_fmt_pkg::PE_WORD_B};
         end
         ctxt_types_pkg::HEADER :
         begin
            word_o.sof     = !PROT_ENG_EN;    // Header leads when there is no PE word.
            word_o.payload = header;
         end
         ctxt_types_pkg::STREAMID : word_o.payload = stream_id_i;
         ctxt_types_pkg::SECS     : word_o.payload = evt_time_i[63:32];
         ctxt_types_pkg::TICS_HI  : word_o.payload = '0;
         ctxt_types_pkg::TICS_LO  : word_o.payload = evt_time_i[31:0];
         ctxt_types_pkg::MESSAGE  : word_o.payload = message_i;
         ctxt_types_pkg::FLOWCTRL :
         begin
            word_o.eof     = 1'b1;
            word_o.payload = {seqnum1_i, seqnum0_i};
         end
         default : word_o = '0;
      endcase
   end

endmodule

/* dv/ctxt_pkt_gen_asserts.sv */
`timescale 1ns/1ns

module ctxt_pkt_gen_asserts
   (input logic                       clk,
    input logic                       rst_n_i,
    input logic                       src_rdy_i,
    input logic                       dst_rdy_i,
    input logic                       sent_i,
    input ctxt_types_pkg::ctxt_word_t data_i);

   // Synchronous reset, outputs quiet from the edge that sees it.
   reset_quiet : assert property (@(posedge clk) !rst_n_i |=> (!src_rdy_i && !sent_i))
      else $error("Output active during reset.");

   hold_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
                                  (src_rdy_i && !dst_rdy_i) |=> $stable(data_i))
      else $error("data_o changed while the consumer stalled.");

   sent_single : assert property (@(posedge clk) disable iff (!rst_n_i) sent_i |=> !sent_i)
      else $error("sent_o high for two cycles.");

endmodule

bind ctxt_pkt_gen ctxt_pkt_gen_asserts ctxt_pkt_gen_asserts_i
  (.clk(clk), .rst_n_i(rst_n_i), .src_rdy_i(src_rdy_o), .dst_rdy_i(dst_rdy_i),
   .sent_i(sent_o), .data_i(data_o));

/* dv/ctxt_pkt_gen_tb.sv */
`timescale 1ns/1ns

module ctxt_pkt_gen_tb;

   logic                       clk;
   logic                       rst_n_i;
   logic                       clear_i;
   logic                       trigger_i;
   logic                       error_i;
   ctxt_types_pkg::stream_id_t stream_id_i;
   ctxt_types_pkg::vita_time_t vita_time_i;
   ctxt_types_pkg::message_t   message_i;
   ctxt_types_pkg::seqnum_t    seqnum0_i;
   ctxt_types_pkg::seqnum_t    seqnum1_i;
   logic                       sent_o;
   ctxt_types_pkg::ctxt_word_t data_o;
   logic                       src_rdy_o;
   logic                       dst_rdy_i;

   ctxt_types_pkg::ctxt_word_t got_q[$];     // Words accepted from the DUT.
   ctxt_types_pkg::pkt_seq_t   model_seq;    // Reference packet count.
   int                         errors;
   int                         checks;
   int                         sent_seen = 0;

   ctxt_pkt_gen #(.PROT_ENG_EN(1'b1)) ctxt_pkt_gen_i
     (.clk(clk), .rst_n_i(rst_n_i), .clear_i(clear_i), .trigger_i(trigger_i),
      .error_i(error_i), .stream_id_i(stream_id_i), .vita_time_i(vita_time_i),
      .message_i(message_i), .seqnum0_i(seqnum0_i), .seqnum1_i(seqnum1_i),
      .sent_o(sent_o), .data_o(data_o), .src_rdy_o(src_rdy_o), .dst_rdy_i(dst_rdy_i));

   always #5 clk = ~clk;

   always @(negedge clk)
   begin
      if (sent_o)
         sent_seen++;
   end

   // ******************************
   // Checks and reference model
   // ******************************

   task automatic report_timeout(input string why);
      errors++;
      $display("%s", why);
   endtask

   task automatic value_error(input string msg);
      errors++;
      $display("ERROR %0t: %s", $time, msg);
   endtask

   task automatic check_word(input ctxt_types_pkg::ctxt_word_t got, exp, input int idx);
      checks++;
      if (got !== exp)
         value_error($sformatf("word %0d is %h, expected %h.", idx, got, exp));
   endtask

   task automatic check_seq(input ctxt_types_pkg::pkt_seq_t got, exp);
      checks++;
      if (got !== exp)
         value_error($sformatf("header sequence %0d, expected %0d.", got, exp));
   endtask

   task automatic check_msg(input ctxt_types_pkg::message_t got, exp);
      checks++;
      if (got !== exp)
         value_error($sformatf("message %h, expected %h.", got, exp));
   endtask

   function automatic ctxt_types_pkg::ctxt_word_t expect_word
     (input int idx, input ctxt_types_pkg::vita_time_t t,
      input ctxt_types_pkg::message_t m, input ctxt_types_pkg::pkt_seq_t s);
      ctxt_types_pkg::ctxt_word_t w;
      w = '0;
      w.sof = (idx == 0);
      w.eof = (idx == 7);
      case (idx)
         0 : w.payload = 32'h0001_001C;               // Protocol-engine word.
         1 : w.payload = {12'h50D, s, 16'h0007};
         2 : w.payload = stream_id_i;
         3 : w.payload = t[63:32];
         5 : w.payload = t[31:0];
         6 : w.payload = m;
         7 : w.payload = {seqnum1_i, seqnum0_i};
         default : w.payload = '0;
      endcase
      return w;
   endfunction

   // ******************************
   // Stimulus
   // ******************************

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic reset_dut();
      rst_n_i = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      model_seq = '0;
   endtask

   task automatic trigger_packet(input ctxt_types_pkg::vita_time_t t);
      step();
      trigger_i = 1'b1;
      vita_time_i = t;
      step();
      trigger_i = 1'b0;
      vita_time_i = ~t;                               // Time must have been captured.
   endtask

   task automatic wait_sent();
      int n;
      n = 0;
      do
      begin
         step();
         n++;
      end
      while (!sent_o && n < 200);
      if (!sent_o)
         report_timeout("Timed out waiting for sent_o.");
   endtask

   task automatic collect_words(input int n_words, input bit stall);
      int n;
      n = 0;
      while (got_q.size() < n_words && n < 400)
      begin
         dst_rdy_i = stall ? ($urandom % 4 == 0) : 1'b1;
         if (src_rdy_o && dst_rdy_i)
            got_q.push_back(data_o);                  // Popped on the next edge.
         step();
         n++;
      end
      dst_rdy_i = 1'b1;
      if (got_q.size() < n_words)
         report_timeout("Timed out collecting packet words.");
   endtask

   task automatic check_packet(input ctxt_types_pkg::vita_time_t t,
                               input ctxt_types_pkg::message_t m);
      ctxt_types_pkg::ctxt_word_t w;
      int                         i;
      for (i = 0; i < 8 && got_q.size() > 0; i++)
      begin
         w = got_q.pop_front();
         check_word(w, expect_word(i, t, m, model_seq), i);
         if (i == 1)
            check_seq(w.payload[19:16], model_seq);
         if (i == 6)
            check_msg(w.payload, m);
      end
      model_seq++;
   endtask

   task automatic run_packet(input ctxt_types_pkg::message_t m);
      ctxt_types_pkg::vita_time_t t;
      t = {$urandom, $urandom};
      fork
         begin
            trigger_packet(t);
            wait_sent();
         end
         collect_words(8, 1'b0);
      join
      check_packet(t, m);
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("Test %s: %s.", name, (errors == err_before) ? "passed" : "failed");
   endtask

   // ******************************
   // Tests
   // ******************************

   task automatic test_single_packet();
      int e;
      int s;
      e = errors;
      s = sent_seen;
      run_packet('0);
      repeat (3) step();
      checks++;
      if (sent_seen - s != 1)
         value_error($sformatf("sent_o pulsed %0d times.", sent_seen - s));
      report_test("single_packet", e);
   endtask

   task automatic test_error_message();
      int                       e;
      ctxt_types_pkg::message_t m;
      e = errors;
      m = $urandom | 32'h1;
      step();
      error_i = 1'b1;
      message_i = m;
      step();
      error_i = 1'b0;
      message_i = ~m;
      run_packet(m);
      run_packet('0);                                 // Cleared by the flow-control word.
      report_test("error_message", e);
   endtask

   task automatic test_back_pressure();
      int                         e;
      int                         i;
      ctxt_types_pkg::vita_time_t times[3];
      e = errors;
      dst_rdy_i = 1'b0;
      fork
         begin
            for (i = 0; i < 3; i++)
            begin
               times[i] = {$urandom, $urandom};
               trigger_packet(times[i]);
               wait_sent();
            end
         end
         collect_words(24, 1'b1);
      join
      for (i = 0; i < 3; i++)
         check_packet(times[i], '0);
      report_test("back_pressure", e);
   endtask

   task automatic test_seq_wrap();
      int e;
      e = errors;
      dst_rdy_i = 1'b0;
      trigger_packet({$urandom, $urandom});
      wait_sent();                                    // Reset lands on a queued packet.
      reset_dut();
      repeat (18) run_packet('0);
      report_test("seq_wrap", e);
   endtask

   task automatic test_busy_trigger();
      int                         e;
      int                         s;
      int                         busy;
      ctxt_types_pkg::vita_time_t t;
      e = errors;
      s = sent_seen;
      t = {$urandom, $urandom};
      fork
         begin
            trigger_packet(t);
            repeat (4)
            begin
               step();
               trigger_i = !trigger_i;
            end
            wait_sent();
         end
         collect_words(8, 1'b0);
      join
      check_packet(t, '0);
      busy = 0;
      repeat (20)
      begin
         step();
         if (src_rdy_o)
            busy++;
      end
      checks++;
      if (busy != 0 || sent_seen - s != 1)
         value_error($sformatf("%0d packets sent, output busy %0d cycles after.",
                               sent_seen - s, busy));
      report_test("busy_trigger", e);
   endtask

   task automatic test_clear();
      int e;
      int n;
      e = errors;
      dst_rdy_i = 1'b0;
      trigger_packet({$urandom, $urandom});
      n = 0;
      while (!src_rdy_o && n < 50)
      begin
         step();
         n++;
      end
      if (!src_rdy_o)
         report_timeout("Timed out waiting for src_rdy_o before the clear.");
      repeat (2) step();
      clear_i = 1'b1;
      step();
      clear_i = 1'b0;
      checks++;
      if (src_rdy_o)
         value_error("src_rdy_o still high after clear_i.");
      model_seq = '0;
      dst_rdy_i = 1'b1;
      run_packet('0);
      report_test("clear", e);
   endtask

   initial
   begin
      void'($urandom(73649));
      clk = 1'b0;
      rst_n_i = 1'b0;
      clear_i = 1'b0;
      trigger_i = 1'b0;
      error_i = 1'b0;
      vita_time_i = '0;
      message_i = '0;
      dst_rdy_i = 1'b1;
      stream_id_i = $urandom;
      seqnum0_i = 16'($urandom);
      seqnum1_i = 16'($urandom);
      errors = 0;
      checks = 0;
      reset_dut();
      test_single_packet();
      test_error_message();
      test_back_pressure();
      test_seq_wrap();
      test_busy_trigger();
      test_clear();
      $display("Tests done, %0d checks, %0d errors.", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module ctxt_pkt_gen_tb
status=0
out=$(./obj_dir/Vctxt_pkt_gen_tb 2>&1) || status=$?
echo "$out"
if [ "$status" -eq 0 ] && echo "$out" | grep -qF '** PASS **'; then
   exit 0
fi
echo "Simulation failed."
exit 1

/* sim.f */
design/ctxt_types_pkg.sv
design/ctxt_fmt_pkg.sv
design/ctxt_seq_fsm.sv
design/ctxt_event_latch.sv
design/ctxt_word_mux.sv
design/ctxt_fifo.sv
design/ctxt_pkt_gen.sv
dv/ctxt_pkt_gen_asserts.sv
dv/ctxt_pkt_gen_tb.sv
